//--- common/dl1c_pkg.sv
package dl1c_pkg;

  // Cache geometry
  localparam int num_ways        = 2;
  localparam int num_sets        = 16;
  localparam int set_width       = 4;
  localparam int line_bytes      = 32;
  localparam int line_width      = line_bytes * 8;
  localparam int word_sel_width  = 3;
  localparam int tag_width       = 23;
  // Tag plus set covers address bits 31 down to 5
  localparam int line_addr_width = tag_width + set_width;

  // Opcodes understood by the level-two cache
  localparam logic [2:0] ltc_opc_read  = 3'd1;
  localparam logic [2:0] ltc_opc_write = 3'd2;

  typedef logic [line_width-1:0] line_t;
  typedef logic [tag_width-1:0]  tag_t;

  // Word address as seen by the cache lookup
  typedef struct packed {
    tag_t                      tag;
    logic [set_width-1:0]      set;
    logic [word_sel_width-1:0] word_sel;
  } cache_addr_t;

  // Same word address as seen by the peripheral decode
  typedef struct packed {
    logic        periph_sel;
    logic [28:0] reg_idx;
  } periph_addr_t;

  // Address bits 31 down to 2
  typedef union packed {
    cache_addr_t  cache;
    periph_addr_t periph;
  } dl1c_addr_t;

  // Core request of 67 bits
  typedef struct packed {
    dl1c_addr_t  addr;
    logic        re;
    logic [3:0]  we;
    logic [31:0] wdata;
  } core_req_t;

  // Request to the level-two arbiter
  typedef struct packed {
    logic                       valid;
    logic [2:0]                 opcode;
    logic [line_addr_width-1:0] line_addr;
    line_t                      wdata;
    logic [line_bytes-1:0]      wbe;
  } l2_req_t;

  // Peripheral bus request
  typedef struct packed {
    logic        re;
    logic [3:0]  we;
    logic [29:0] addr;
    logic [31:0] wdata;
  } periph_req_t;

endpackage

//--- hdl/dl1c_ctrl.sv
module dl1c_ctrl
  import dl1c_pkg::*;
(
  input  logic      clkrst_mem_clk,
  input  logic      clkrst_mem_rst_n,
  input  core_req_t core_req,
  output core_req_t req_1a,
  input  logic      hit,
  input  logic      rvalid,
  input  logic      stall,
  output logic      ready,
  output logic      read_addr_imm,
  output logic      issue_read,
  output logic      issue_write,
  output logic      fill,
  output logic      write_hit,
  output logic      periph_op
);

  logic pending_0a;
  logic is_periph_0a;
  logic pending_1a;
  logic cache_req_1a;
  logic miss_1a;

  // Work still owed to the latched request
  logic read_remaining;
  logic write_remaining;
  logic periph_remaining;

  assign pending_0a   = core_req.re | (|core_req.we);
  assign is_periph_0a = core_req.addr.periph.periph_sel;
  assign pending_1a   = req_1a.re | (|req_1a.we);

  // Peripheral requests never look at the cache arrays
  assign cache_req_1a = pending_1a & ~periph_remaining;
  assign miss_1a      = cache_req_1a & ~hit;

  always_comb begin
    ready       = 1'b0;
    issue_read  = 1'b0;
    issue_write = 1'b0;
    fill        = 1'b0;
    periph_op   = 1'b0;

    if (miss_1a) begin
      // Refill first; the read goes out once, then wait for the data
      if (!stall) begin
        issue_read = read_remaining;
        fill       = ~read_remaining & rvalid;
      end
    end else if (write_remaining) begin
      // Line is resident, so write through
      if (!stall) begin
        issue_write = 1'b1;
      end
    end else begin
      ready     = 1'b1;
      // Peripheral access happens in the accept cycle itself
      periph_op = pending_0a & is_periph_0a;
    end
  end

  assign write_hit = issue_write & hit;

  // Arrays follow the incoming address only when a new request can be taken
  assign read_addr_imm = ready;

  always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
    if (!clkrst_mem_rst_n) begin
      req_1a           <= '0;
      read_remaining   <= 1'b0;
      write_remaining  <= 1'b0;
      periph_remaining <= 1'b0;
    end else if (ready) begin
      req_1a           <= core_req;
      read_remaining   <= 1'b1;
      write_remaining  <= (|core_req.we) & ~is_periph_0a;
      // Result comes back from the peripheral port in stage 1
      periph_remaining <= periph_op;
    end else begin
      if (issue_read) begin
        read_remaining <= 1'b0;
      end
      if (issue_write) begin
        write_remaining <= 1'b0;
      end
    end
  end

endmodule

//--- dl1c_line_store/dl1c_line_store.sv
module dl1c_line_store
  import dl1c_pkg::*;
(
  input  logic      clkrst_mem_clk,
  input  logic      clkrst_mem_rst_n,
  input  core_req_t core_req,
  input  core_req_t req_1a,
  input  logic      read_addr_imm,
  input  logic      fill,
  input  logic      write_hit,
  input  line_t     refill_line,
  input  line_t     merged_line,
  output logic      hit,
  output line_t     hit_line
);

  // Tag and data arrays, one per way
  line_t data_mem [num_ways][num_sets];
  tag_t  tag_mem  [num_ways][num_sets];

  logic [num_sets-1:0] valid [num_ways];
  // Per set, the way to replace on the next refill
  logic [num_sets-1:0] evict;

  line_t q_data [num_ways];
  tag_t  q_tag  [num_ways];

  logic [set_width-1:0] rd_set;
  logic [set_width-1:0] set_1a;
  tag_t                 tag_1a;
  logic [num_ways-1:0]  hit_way_vec;
  logic                 hit_way;
  logic                 victim;
  logic                 pending_1a;
  logic [num_ways-1:0]  way_we;
  line_t                wr_line;

  assign set_1a     = req_1a.addr.cache.set;
  assign tag_1a     = req_1a.addr.cache.tag;
  assign pending_1a = req_1a.re | (|req_1a.we);

  assign rd_set = read_addr_imm ? core_req.addr.cache.set : set_1a;

  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      hit_way_vec[w] = valid[w][set_1a] && (q_tag[w] == tag_1a);
    end
  end

  assign hit = |hit_way_vec;
  // With two ways the hitting way index is just the way 1 match
  assign hit_way  = hit_way_vec[1];
  assign hit_line = q_data[hit_way];
  assign victim   = evict[set_1a];

  always_comb begin
    way_we  = '0;
    wr_line = merged_line;
    if (fill) begin
      way_we[victim] = 1'b1;
      wr_line        = refill_line;
    end else if (write_hit) begin
      way_we[hit_way] = 1'b1;
    end
  end

  // Read-before-write arrays with a registered output
  always_ff @(posedge clkrst_mem_clk) begin
    for (int w = 0; w < num_ways; w++) begin
      if (way_we[w]) begin
        data_mem[w][set_1a] <= wr_line;
        tag_mem[w][set_1a]  <= tag_1a;
      end
      q_data[w] <= data_mem[w][rd_set];
      q_tag[w]  <= tag_mem[w][rd_set];
    end
  end

  always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
    if (!clkrst_mem_rst_n) begin
      for (int w = 0; w < num_ways; w++) begin
        valid[w] <= '0;
      end
      evict <= '0;
    end else begin
      if (fill) begin
        valid[victim][set_1a] <= 1'b1;
      end
      // After a hit the other way becomes the next victim
      if (pending_1a && hit) begin
        evict[set_1a] <= ~hit_way;
      end
    end
  end

endmodule

//--- hdl/dl1c_l2_port.sv
module dl1c_l2_port
  import dl1c_pkg::*;
(
  input  logic      clkrst_mem_clk,
  input  logic      clkrst_mem_rst_n,
  input  core_req_t req_1a,
  input  line_t     hit_line,
  input  logic      issue_read,
  input  logic      issue_write,
  input  logic      stall,
  output line_t     merged_line,
  output l2_req_t   arb_req
);

  logic [31:0]           bit_mask;
  logic [7:0]            bit_shift;
  logic [4:0]            byte_shift;
  line_t                 line_mask;
  line_t                 line_wdata;
  logic [line_bytes-1:0] wbe_base;
  logic [line_bytes-1:0] line_wbe;

  // One mask byte per enabled byte lane
  assign bit_mask = {{8{req_1a.we[3]}}, {8{req_1a.we[2]}},
                     {8{req_1a.we[1]}}, {8{req_1a.we[0]}}};

  assign bit_shift  = {req_1a.addr.cache.word_sel, 5'd0};
  assign byte_shift = {req_1a.addr.cache.word_sel, 2'd0};

  assign line_mask  = line_t'(bit_mask) << bit_shift;
  assign line_wdata = line_t'(req_1a.wdata & bit_mask) << bit_shift;

  // Keep the untouched bytes of the resident line
  assign merged_line = (hit_line & ~line_mask) | line_wdata;

  assign wbe_base = {{(line_bytes - 4){1'b0}}, req_1a.we};
  assign line_wbe = wbe_base << byte_shift;

  // Request register holds its value while the arbiter stalls
  always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
    if (!clkrst_mem_rst_n) begin
      arb_req.valid <= 1'b0;
    end else if (!stall) begin
      arb_req.valid <= issue_read | issue_write;
      if (issue_read || issue_write) begin
        arb_req.opcode    <= issue_write ? ltc_opc_write : ltc_opc_read;
        arb_req.line_addr <= {req_1a.addr.cache.tag, req_1a.addr.cache.set};
        arb_req.wdata     <= merged_line;
        arb_req.wbe       <= line_wbe;
      end
    end
  end

endmodule

//--- hdl/dl1c_periph_port.sv
module dl1c_periph_port
  import dl1c_pkg::*;
(
  input  logic        clkrst_mem_clk,
  input  logic        clkrst_mem_rst_n,
  input  core_req_t   core_req,
  input  logic        periph_op,
  input  logic [31:0] periph_rdata,
  output periph_req_t periph_req,
  output logic [31:0] periph_result
);

  // Bus is idle unless a peripheral request is being accepted
  always_comb begin
    periph_req = '0;
    if (periph_op) begin
      periph_req.re    = core_req.re;
      periph_req.we    = core_req.we;
      periph_req.addr  = core_req.addr;
      periph_req.wdata = core_req.wdata;
    end
  end

  // Peripherals answer within the cycle, so the data is held for stage 1
  always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
    if (!clkrst_mem_rst_n) begin
      periph_result <= '0;
    end else if (periph_op) begin
      periph_result <= periph_rdata;
    end
  end

endmodule

//--- hdl/dl1c_top.sv
module dl1c_top
  import dl1c_pkg::*;
(
  input  logic        clkrst_mem_clk,
  input  logic        clkrst_mem_rst_n,
  input  core_req_t   core_req,
  output logic [31:0] dl1c_out,
  output logic        dl1c_ready,
  output l2_req_t     dl1c2arb_req,
  input  line_t       dl1c2arb_rdata,
  input  logic        dl1c2arb_rvalid,
  input  logic        dl1c2arb_stall,
  output periph_req_t dl1c2periph_req,
  input  logic [31:0] dl1c2periph_rdata
);

  core_req_t   req_1a;
  logic        hit;
  logic        read_addr_imm;
  logic        issue_read;
  logic        issue_write;
  logic        fill;
  logic        write_hit;
  logic        periph_op;
  line_t       hit_line;
  line_t       merged_line;
  logic [31:0] periph_result;
  logic [7:0]  word_bit;

  dl1c_ctrl u_ctrl (
    .clkrst_mem_clk   (clkrst_mem_clk),
    .clkrst_mem_rst_n (clkrst_mem_rst_n),
    .core_req         (core_req),
    .req_1a           (req_1a),
    .hit              (hit),
    .rvalid           (dl1c2arb_rvalid),
    .stall            (dl1c2arb_stall),
    .ready            (dl1c_ready),
    .read_addr_imm    (read_addr_imm),
    .issue_read       (issue_read),
    .issue_write      (issue_write),
    .fill             (fill),
    .write_hit        (write_hit),
    .periph_op        (periph_op)
  );

  dl1c_line_store u_line_store (
    .clkrst_mem_clk   (clkrst_mem_clk),
    .clkrst_mem_rst_n (clkrst_mem_rst_n),
    .core_req         (core_req),
    .req_1a           (req_1a),
    .read_addr_imm    (read_addr_imm),
    .fill             (fill),
    .write_hit        (write_hit),
    .refill_line      (dl1c2arb_rdata),
    .merged_line      (merged_line),
    .hit              (hit),
    .hit_line         (hit_line)
  );

  dl1c_l2_port u_l2_port (
    .clkrst_mem_clk   (clkrst_mem_clk),
    .clkrst_mem_rst_n (clkrst_mem_rst_n),
    .req_1a           (req_1a),
    .hit_line         (hit_line),
    .issue_read       (issue_read),
    .issue_write      (issue_write),
    .stall            (dl1c2arb_stall),
    .merged_line      (merged_line),
    .arb_req          (dl1c2arb_req)
  );

  dl1c_periph_port u_periph_port (
    .clkrst_mem_clk   (clkrst_mem_clk),
    .clkrst_mem_rst_n (clkrst_mem_rst_n),
    .core_req         (core_req),
    .periph_op        (periph_op),
    .periph_rdata     (dl1c2periph_rdata),
    .periph_req       (dl1c2periph_req),
    .periph_result    (periph_result)
  );

  // Bit offset of the requested word within the line
  assign word_bit = {req_1a.addr.cache.word_sel, 5'd0};

  assign dl1c_out = req_1a.addr.periph.periph_sel ? periph_result
                                                  : hit_line[word_bit +: 32];

endmodule

//--- verification/dl1c_tb.sv
module dl1c_tb
  import dl1c_pkg::*;
;

  typedef struct {
    logic [31:0] addr;
    logic        re;
    logic [3:0]  we;
    logic [31:0] wdata;
    int          n_rd;
    int          n_wr;
    int          lat;
  } entry_t;

  localparam int num_entries = 16;
  localparam int cycle_limit = 40 * num_entries + 20;

  logic        clkrst_mem_clk = 1'b0;
  logic        clkrst_mem_rst_n;
  core_req_t   core_req;
  logic [31:0] dl1c_out;
  logic        dl1c_ready;
  l2_req_t     dl1c2arb_req;
  line_t       dl1c2arb_rdata;
  logic        dl1c2arb_rvalid;
  logic        dl1c2arb_stall;
  periph_req_t dl1c2periph_req;
  logic [31:0] dl1c2periph_rdata;

  entry_t      tbl [num_entries];
  logic [15:0] lfsr = 16'd78;
  int          cycles = 0;
  int          rd_left = 0;
  int          wr_left = 0;
  logic [31:0] cur_addr;
  // Write enables of the current entry
  logic [3:0]  cur_we;
  logic [31:0] ref_mem [logic [29:0]];
  line_t       l2_mem [logic [26:0]];
  logic [31:0] periph_regs [16];
  logic [31:0] periph_ref [16];
  logic        rd_pending = 1'b0;
  int          rd_count = 0;
  logic [26:0] rd_line_addr;

  dl1c_top dut (.*);

  always #5 clkrst_mem_clk = ~clkrst_mem_clk;

  assign dl1c2periph_rdata = periph_regs[dl1c2periph_req.addr[3:0]];

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic lsb;
    lsb = s[0];
    s = s >> 1;
    if (lsb) s = s ^ 16'hB400;
    return s;
  endfunction

  function automatic logic take_bit();
    lfsr = lfsr_step(lfsr);
    return lfsr[0];
  endfunction

  // Preload pattern depends on the full word address
  function automatic logic [31:0] init_word(input logic [29:0] a);
    return (32'(a) * 32'h9E37_79B1) ^ 32'h5A5A_1234;
  endfunction

  function automatic logic [31:0] ref_word(input logic [29:0] a);
    return ref_mem.exists(a) ? ref_mem[a] : init_word(a);
  endfunction

  function automatic line_t ref_line(input logic [26:0] la);
    line_t l;
    for (int w = 0; w < 8; w++) l[w*32 +: 32] = ref_word({la, 3'(w)});
    return l;
  endfunction

  function automatic line_t l2_line(input logic [26:0] la);
    line_t l;
    if (l2_mem.exists(la)) return l2_mem[la];
    for (int w = 0; w < 8; w++) l[w*32 +: 32] = init_word({la, 3'(w)});
    return l;
  endfunction

  task automatic report_fail(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      report_fail($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_l2_req(input string name, input l2_req_t got, input l2_req_t exp);
    logic bad;
    bad = got.valid !== exp.valid;
    if (exp.valid) begin
      bad |= got.opcode !== exp.opcode || got.line_addr !== exp.line_addr;
      if (exp.opcode == ltc_opc_write) bad |= got.wdata !== exp.wdata || got.wbe !== exp.wbe;
    end
    if (bad) begin
      report_fail($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_periph_req(input string name, input periph_req_t got,
                                  input periph_req_t exp);
    if (got !== exp) begin
      report_fail($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // L2 model takes a request in a cycle with valid high and stall low
  always @(negedge clkrst_mem_clk) begin
    l2_req_t exp;
    line_t   l;
    if (clkrst_mem_rst_n && dl1c2arb_req.valid && !dl1c2arb_stall) begin
      exp = '0;
      exp.valid = 1'b1;
      exp.line_addr = cur_addr[31:5];
      if (rd_left > 0) begin
        exp.opcode = ltc_opc_read;
        rd_left--;
      end else if (wr_left > 0) begin
        exp.opcode = ltc_opc_write;
        exp.wdata = ref_line(cur_addr[31:5]);
        exp.wbe = 32'(cur_we) << (cur_addr[4:2] * 4);
        wr_left--;
      end else begin
        report_fail($sformatf("Unexpected arbiter request at %0t", $time));
      end
      check_l2_req("dl1c2arb_req", dl1c2arb_req, exp);
      if (exp.opcode == ltc_opc_read) begin
        rd_pending = 1'b1;
        rd_count = 2 + {take_bit(), take_bit()};
        rd_line_addr = dl1c2arb_req.line_addr;
      end else begin
        l = l2_line(dl1c2arb_req.line_addr);
        for (int b = 0; b < 32; b++) begin
          if (dl1c2arb_req.wbe[b]) l[b*8 +: 8] = dl1c2arb_req.wdata[b*8 +: 8];
        end
        l2_mem[dl1c2arb_req.line_addr] = l;
      end
    end
  end

  always @(posedge clkrst_mem_clk) begin
    if (clkrst_mem_rst_n) begin
      dl1c2arb_rvalid <= 1'b0;
      if (rd_pending && rd_count == 0) begin
        dl1c2arb_rvalid <= 1'b1;
        dl1c2arb_rdata  <= l2_line(rd_line_addr);
        dl1c2arb_stall  <= 1'b0;
        rd_pending = 1'b0;
      end else begin
        if (rd_pending) rd_count--;
        // Stall on about one cycle in four
        dl1c2arb_stall <= take_bit() & take_bit();
      end
    end
  end

  // Peripheral register writes
  always @(negedge clkrst_mem_clk) begin
    for (int b = 0; b < 4; b++) begin
      if (dl1c2periph_req.we[b]) begin
        periph_regs[dl1c2periph_req.addr[3:0]][b*8 +: 8] <= dl1c2periph_req.wdata[b*8 +: 8];
      end
    end
  end

  always @(posedge clkrst_mem_clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run exceeded %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic run_entry(input entry_t e);
    periph_req_t exp_p;
    logic [31:0] exp_out;
    logic [31:0] w;
    int          lat;
    cur_addr = e.addr;
    cur_we = e.we;
    rd_left = e.n_rd;
    wr_left = e.n_wr;
    if (e.addr[31]) begin
      for (int b = 0; b < 4; b++) begin
        if (e.we[b]) begin
          periph_ref[e.addr[5:2]][b*8 +: 8] = e.wdata[b*8 +: 8];
        end
      end
      exp_out = periph_ref[e.addr[5:2]];
    end else begin
      w = ref_word(e.addr[31:2]);
      for (int b = 0; b < 4; b++) begin
        if (e.we[b]) begin
          w[b*8 +: 8] = e.wdata[b*8 +: 8];
        end
      end
      ref_mem[e.addr[31:2]] = w;
      exp_out = w;
    end
    @(posedge clkrst_mem_clk);
    core_req <= '{addr: e.addr[31:2], re: e.re, we: e.we, wdata: e.wdata};
    @(negedge clkrst_mem_clk);
    while (!dl1c_ready) @(negedge clkrst_mem_clk);
    exp_p = '0;
    if (e.addr[31]) exp_p = '{re: e.re, we: e.we, addr: e.addr[31:2], wdata: e.wdata};
    check_periph_req("dl1c2periph_req", dl1c2periph_req, exp_p);
    @(posedge clkrst_mem_clk);
    core_req <= '0;
    lat = 0;
    do begin
      @(negedge clkrst_mem_clk);
      lat++;
    end while (!dl1c_ready);
    if (e.re) check_word("dl1c_out", dl1c_out, exp_out);
    if (e.lat != 0) check_word("request latency", lat, e.lat);
    // A write-through may still sit in the stalled request register
    while (dl1c2arb_req.valid) @(negedge clkrst_mem_clk);
    check_word("missing arbiter reads", rd_left, 0);
    check_word("missing arbiter writes", wr_left, 0);
  endtask

  initial begin
    clkrst_mem_rst_n = 1'b0;
    core_req = '0;
    dl1c2arb_rdata = '0;
    dl1c2arb_rvalid = 1'b0;
    dl1c2arb_stall = 1'b0;
    cur_we = '0;
    cur_addr = '0;
    for (int i = 0; i < 16; i++) begin
      periph_regs[i] = 32'hC0DE_0000 | (i * 32'h0111);
      periph_ref[i] = 32'hC0DE_0000 | (i * 32'h0111);
    end
    // Columns are byte address, re, we, wdata, arbiter reads, arbiter writes and latency
    tbl[0]  = '{32'h0000_1004, 1'b1, 4'h0, 32'h0, 1, 0, 0};
    tbl[1]  = '{32'h0000_1008, 1'b1, 4'h0, 32'h0, 0, 0, 1};
    tbl[2]  = '{32'h0000_101C, 1'b1, 4'h0, 32'h0, 0, 0, 1};
    tbl[3]  = '{32'h0000_1008, 1'b0, 4'h6, 32'hAABB_CCDD, 0, 1, 0};
    tbl[4]  = '{32'h0000_1008, 1'b1, 4'h0, 32'h0, 0, 0, 1};
    tbl[5]  = '{32'h0000_2000, 1'b1, 4'h0, 32'h0, 1, 0, 0};
    tbl[6]  = '{32'h0000_1000, 1'b1, 4'h0, 32'h0, 0, 0, 1};
    tbl[7]  = '{32'h0000_3010, 1'b1, 4'h0, 32'h0, 1, 0, 0};
    tbl[8]  = '{32'h0000_1014, 1'b1, 4'h0, 32'h0, 0, 0, 1};
    tbl[9]  = '{32'h0000_2004, 1'b1, 4'h0, 32'h0, 1, 0, 0};
    tbl[10] = '{32'h0000_4020, 1'b0, 4'hF, 32'h0BAD_F00D, 1, 1, 0};
    tbl[11] = '{32'h0000_4020, 1'b1, 4'h0, 32'h0, 0, 0, 1};
    tbl[12] = '{32'h8000_0010, 1'b0, 4'hF, 32'h1234_5678, 0, 0, 1};
    tbl[13] = '{32'h8000_0010, 1'b1, 4'h0, 32'h0, 0, 0, 1};
    tbl[14] = '{32'h8000_0024, 1'b1, 4'h0, 32'h0, 0, 0, 1};
    tbl[15] = '{32'h0000_1008, 1'b1, 4'h0, 32'h0, 0, 0, 1};
    repeat (5) @(posedge clkrst_mem_clk);
    clkrst_mem_rst_n <= 1'b1;
    @(negedge clkrst_mem_clk);
    check_word("dl1c_ready", dl1c_ready, 32'd1);
    check_l2_req("dl1c2arb_req", dl1c2arb_req, '0);
    check_periph_req("dl1c2periph_req", dl1c2periph_req, '0);
    for (int i = 0; i < num_entries; i++) run_entry(tbl[i]);
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- compile.f
common/dl1c_pkg.sv
hdl/dl1c_ctrl.sv
dl1c_line_store/dl1c_line_store.sv
hdl/dl1c_l2_port.sv
hdl/dl1c_periph_port.sv
hdl/dl1c_top.sv
verification/dl1c_tb.sv

//--- Bender.yml
package:
  name: dl1c

sources:
  - common/dl1c_pkg.sv
  - hdl/dl1c_ctrl.sv
  - dl1c_line_store/dl1c_line_store.sv
  - hdl/dl1c_l2_port.sv
  - hdl/dl1c_periph_port.sv
  - hdl/dl1c_top.sv
  - target: test
    files:
      - verification/dl1c_tb.sv
